/* all.f */
source/lsu_pkg.sv
source/lsq.sv
source/mem_stage.sv
source/data_mem.sv
source/lsu_writeback.sv
source/lsu_top.sv
dv/lsu_assert.sv
dv/lsu_tb.sv

/* run.sh */
#!/bin/sh
# Build the LSU testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

# Error limit raised so that bound assertion failures reach the final report
verilator --binary --timing --assert --top-module lsu_tb -f all.f -o lsu_sim \
  && ./obj_dir/lsu_sim +verilator+error+limit+1000 > sim.log 2>&1 \
  || echo "build or simulation ended with an error"

cat sim.log 2>/dev/null
grep -q "STATUS: PASS" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

/* dv/lsu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_tb import lsu_pkg::*; ();

  localparam int LSQ_SIZE   = 8;
  localparam int MEM_DEPTH  = 256;
  localparam int HALF_CLK   = 50;
  localparam int DRV_DLY    = 1;
  localparam int WAIT_LIMIT = 40;

  logic    clk;
  logic    arst_n;
  logic    op_strobe;
  mem_op_t op;
  logic    drain_en;
  logic    result_valid;
  result_t result;
  logic    full;
  logic    overflow;

  // Reference model: shadow memory, shadow queue, pending results
  word_t   shadow_mem [MEM_DEPTH];
  addr_t   sq_addr [$];
  word_t   sq_data [$];
  result_t exp_res [$];
  int      exp_due [$];
  int      cyc;
  int      checks;
  int      errors;
  int      failed_tests;
  logic    drain_level;
  tag_t    next_tag;

  lsu_top #(
    .LSQ_SIZE  (LSQ_SIZE),
    .MEM_DEPTH (MEM_DEPTH)
  ) i_dut (
    .clk          (clk),
    .arst_n       (arst_n),
    .op_strobe    (op_strobe),
    .op           (op),
    .drain_en     (drain_en),
    .result_valid (result_valid),
    .result       (result),
    .full         (full),
    .overflow     (overflow)
  );

  // Protocol checks inside the top level
  bind lsu_top lsu_assert i_lsu_assert (
    .clk          (clk),
    .arst_n       (arst_n),
    .accept       (accept),
    .result_valid (result_valid),
    .result       (result),
    .full         (full),
    .overflow     (overflow)
  );

  initial clk = 1'b0;
  always #HALF_CLK clk = ~clk;

  // Preload word, a function of every address bit
  function automatic word_t fill_word(addr_t a);
    return {a, ~a} ^ 16'h3c96;
  endfunction

  function automatic int total_errors();
    return errors + i_dut.i_lsu_assert.fail_count;
  endfunction

  task automatic check_eq(string name, logic [31:0] got, logic [31:0] want);
    checks++;
    assert (got === want) else begin
      $display("Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, want, got);
      errors++;
    end
  endtask

  // Youngest queued store to the address, else memory
  function automatic logic find_store(addr_t a, output word_t v);
    for (int i = sq_addr.size() - 1; i >= 0; i--) begin
      if (sq_addr[i] == a) begin
        v = sq_data[i];
        return 1'b1;
      end
    end
    v = shadow_mem[a];
    return 1'b0;
  endfunction

  // Outputs against the model, state before the coming edge
  task automatic check_outputs();
    result_t want;
    check_eq("full", 32'(full), 32'(sq_addr.size() == LSQ_SIZE));
    check_eq("overflow", 32'(overflow),
             32'(op_strobe && (op.kind == OP_STORE) && (sq_addr.size() == LSQ_SIZE)));
    if (result_valid) begin
      if (exp_res.size() == 0) begin
        $display("Error at %0t ns: result_valid high with no operation pending", $time);
        errors++;
      end else begin
        want = exp_res.pop_front();
        check_eq("result_valid cycle", 32'(cyc), 32'(exp_due.pop_front()));
        check_eq("result.tag", 32'(result.tag), 32'(want.tag));
        check_eq("result.value", 32'(result.value), 32'(want.value));
        check_eq("result.forwarded", 32'(result.forwarded), 32'(want.forwarded));
      end
    end else if ((exp_due.size() > 0) && (exp_due[0] <= cyc)) begin
      $display("Error at %0t ns: no result came for tag 0x%0h", $time, exp_res[0].tag);
      errors++;
      exp_res.delete(0);
      exp_due.delete(0);
    end
  endtask

  // Effect of the coming edge: drain, allocate, then the lookup
  task automatic model_edge();
    logic    do_drain;
    logic    do_alloc;
    result_t want;
    word_t   v;
    do_drain = drain_en && (sq_addr.size() > 0);
    do_alloc = op_strobe && (op.kind == OP_STORE) && (sq_addr.size() < LSQ_SIZE);
    if (do_drain) begin
      shadow_mem[sq_addr[0]] = sq_data[0];
      sq_addr.delete(0);
      sq_data.delete(0);
    end
    if (do_alloc) begin
      sq_addr.push_back(op.address);
      sq_data.push_back(op.data);
    end
    // Dropped store gives no result
    if (op_strobe && ((op.kind == OP_LOAD) || do_alloc)) begin
      want.tag = op.tag;
      if (op.kind == OP_STORE) begin
        want.value     = op.data;
        want.forwarded = 1'b0;
      end else begin
        want.forwarded = find_store(op.address, v);
        want.value     = v;
      end
      exp_res.push_back(want);
      exp_due.push_back(cyc + 3);
    end
  endtask

  // Mid-cycle, inputs and outputs are stable here
  always @(negedge clk) begin
    if (arst_n) begin
      cyc++;
      check_outputs();
      model_edge();
    end
  end

  task automatic drive(logic strobe, op_kind_e kind, addr_t addr, word_t data);
    @(posedge clk);
    #DRV_DLY;
    op_strobe  = strobe;
    op.kind    = kind;
    op.tag     = next_tag;
    op.address = addr;
    op.data    = data;
    drain_en   = drain_level;
    if (strobe) begin
      next_tag++;
    end
  endtask

  // Idle until all results are back and, with draining on, the queue is empty
  task automatic idle_until_done();
    int n;
    n = 0;
    do begin
      drive(1'b0, OP_LOAD, '0, '0);
      n++;
    end while (((exp_res.size() > 0) || (drain_level && (sq_addr.size() > 0)))
               && (n < WAIT_LIMIT));
    if ((exp_res.size() > 0) || (drain_level && (sq_addr.size() > 0))) begin
      $display("Timeout at %0t ns: results or queue drain still pending", $time);
      errors++;
    end
  endtask

  task automatic report_test(string name, int err_before);
    if (total_errors() == err_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, total_errors() - err_before);
      failed_tests++;
    end
  endtask

  initial begin
    int e;
    op_kind_e kind;
    void'($urandom(32'h857b));
    arst_n       = 1'b0;
    op_strobe    = 1'b0;
    op           = '0;
    drain_en     = 1'b0;
    drain_level  = 1'b0;
    next_tag     = '0;
    cyc          = 0;
    checks       = 0;
    errors       = 0;
    failed_tests = 0;
    for (int a = 0; a < MEM_DEPTH; a++) begin
      shadow_mem[a]           = fill_word(addr_t'(a));
      i_dut.i_data_mem.mem[a] = fill_word(addr_t'(a));
    end
    repeat (3) @(posedge clk);
    #DRV_DLY;
    arst_n = 1'b1;

    // Back-to-back store and load
    e = total_errors();
    drive(1'b1, OP_STORE, 8'h10, 16'h1234);
    drive(1'b1, OP_LOAD, 8'h10, '0);
    idle_until_done();
    drain_level = 1'b1;
    idle_until_done();
    report_test("store_forward", e);

    // Youngest of three; the 0x21 store first shifts colors across the wrap
    e = total_errors();
    for (int r = 0; r < 5; r++) begin
      drain_level = 1'b0;
      drive(1'b1, OP_STORE, 8'h21, word_t'(16'h2100 + r));
      for (int k = 0; k < 3; k++) begin
        drive(1'b1, OP_STORE, 8'h20, word_t'(16'h2000 + r * 16 + k));
      end
      drive(1'b1, OP_LOAD, 8'h20, '0);
      drive(1'b1, OP_LOAD, 8'h21, '0);
      drain_level = 1'b1;
      idle_until_done();
    end
    report_test("youngest_store", e);

    // Drained store and untouched address both come from memory
    e = total_errors();
    drive(1'b1, OP_STORE, 8'h30, 16'hbeef);
    idle_until_done();
    drive(1'b1, OP_LOAD, 8'h30, '0);
    drive(1'b1, OP_LOAD, 8'h77, '0);
    idle_until_done();
    report_test("memory_read", e);

    // Fill the queue, then one dropped store and loads that still return
    e = total_errors();
    drain_level = 1'b0;
    for (int k = 0; k < LSQ_SIZE; k++) begin
      drive(1'b1, OP_STORE, addr_t'(8'h50 + k), word_t'(16'h5000 + k));
    end
    drive(1'b1, OP_STORE, 8'h5f, 16'hdead);
    drive(1'b1, OP_LOAD, 8'h52, '0);
    drive(1'b1, OP_LOAD, 8'h5f, '0);
    idle_until_done();
    drain_level = 1'b1;
    idle_until_done();
    report_test("queue_full", e);

    // Random mix over a narrow address window
    e = total_errors();
    for (int n = 0; n < 200; n++) begin
      drain_level = ($urandom_range(0, 1) == 1);
      kind = ($urandom_range(0, 1) == 1) ? OP_STORE : OP_LOAD;
      drive(($urandom_range(0, 3) != 0), kind, addr_t'(8'h40 + $urandom_range(0, 7)),
            word_t'($urandom));
    end
    drain_level = 1'b1;
    idle_until_done();
    report_test("random_mix", e);

    $display("tests: 5 run, %0d failed, checks: %0d, errors: %0d",
             failed_tests, checks, total_errors());
    if (total_errors() == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dv/lsu_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_assert import lsu_pkg::*; (
  input logic    clk,
  input logic    arst_n,
  input logic    accept,
  input logic    result_valid,
  input result_t result,
  input logic    full,
  input logic    overflow
);

  // Count of failed assertions
  int fail_count = 0;

  // One result pulse two edges after each accepted op
  // Sampled values lag the register outputs by one tick
  a_result_timing: assert property (
    @(posedge clk) disable iff (!arst_n)
    result_valid == $past(accept, RESULT_LATENCY + 1)
  ) else begin
    $error("result_valid does not follow an accepted operation by two cycles");
    fail_count++;
  end

  // Drop pulse only when no slot is free, and the dropped store never returns
  a_overflow_full: assert property (
    @(posedge clk) disable iff (!arst_n)
    overflow |-> full ##(RESULT_LATENCY + 1) !result_valid
  ) else begin
    $error("overflow raised while not full, or the dropped store produced a result");
    fail_count++;
  end

  // Outputs quiet while reset is held
  a_reset_outputs: assert property (
    @(posedge clk)
    !arst_n |-> (!result_valid && !full && !overflow && (result == '0))
  ) else begin
    $error("outputs not cleared during reset");
    fail_count++;
  end

endmodule

`default_nettype wire

/* source/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_top import lsu_pkg::*; #(
  parameter int LSQ_SIZE  = LSQ_SIZE_DEF,
  parameter int MEM_DEPTH = MEM_DEPTH_DEF
) (
  input  logic    clk,
  input  logic    arst_n,
  input  logic    op_strobe,
  input  mem_op_t op,
  input  logic    drain_en,
  output logic    result_valid,
  output result_t result,
  output logic    full,
  output logic    overflow
);

  lsq_entry_t entries [LSQ_SIZE];
  logic       store_strobe;
  logic       accept;
  logic       mem_wr_en;
  addr_t      mem_wr_addr;
  word_t      mem_wr_data;
  addr_t      rd_addr;
  word_t      rd_data;
  lookup_t    lookup;

  // Only stores enter the queue
  assign store_strobe = op_strobe && (op.kind == OP_STORE);

  // Dropped stores never reach the pipeline
  assign accept = op_strobe && !(store_strobe && full);

  // Store queue and drain to memory
  lsq #(
    .LSQ_SIZE (LSQ_SIZE)
  ) i_lsq (
    .clk          (clk),
    .arst_n       (arst_n),
    .store_strobe (store_strobe),
    .op           (op),
    .drain_en     (drain_en),
    .entries      (entries),
    .mem_wr_en    (mem_wr_en),
    .mem_wr_addr  (mem_wr_addr),
    .mem_wr_data  (mem_wr_data),
    .full         (full),
    .overflow     (overflow)
  );

  // Queue search and stage register
  mem_stage #(
    .LSQ_SIZE (LSQ_SIZE)
  ) i_mem_stage (
    .clk       (clk),
    .arst_n    (arst_n),
    .op_strobe (accept),
    .op        (op),
    .entries   (entries),
    .rd_addr   (rd_addr),
    .lookup    (lookup)
  );

  data_mem #(
    .MEM_DEPTH (MEM_DEPTH)
  ) i_data_mem (
    .clk     (clk),
    .wr_en   (mem_wr_en),
    .wr_addr (mem_wr_addr),
    .wr_data (mem_wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  // Result select and output register
  lsu_writeback i_lsu_writeback (
    .clk          (clk),
    .arst_n       (arst_n),
    .lookup       (lookup),
    .rd_data      (rd_data),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

`default_nettype wire

/* source/lsu_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_writeback import lsu_pkg::*; (
  input  logic    clk,
  input  logic    arst_n,
  input  lookup_t lookup,
  input  word_t   rd_data,
  output logic    result_valid,
  output result_t result
);

  word_t sel_value;
  logic  load_hit;

  // Forwarded only when a load found a queued store
  assign load_hit = lookup.hit && (lookup.kind == OP_LOAD);

  // Queue value on a hit, memory word otherwise
  assign sel_value = lookup.hit ? lookup.value : rd_data;

  // Result register, one pulse per op
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result_valid <= 1'b0;
      result       <= '0;
    end else begin
      result_valid <= lookup.valid;
      // Hold last result between ops
      if (lookup.valid) begin
        result.tag       <= lookup.tag;
        result.value     <= sel_value;
        result.forwarded <= load_hit;
      end
    end
  end

endmodule

`default_nettype wire

/* source/data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module data_mem import lsu_pkg::*; #(
  parameter int MEM_DEPTH = MEM_DEPTH_DEF
) (
  input  logic  clk,
  input  logic  wr_en,
  input  addr_t wr_addr,
  input  word_t wr_data,
  input  addr_t rd_addr,
  output word_t rd_data
);

  localparam int IDX_W = $clog2(MEM_DEPTH);

  // Word array, preloaded by the testbench
  word_t mem [MEM_DEPTH];

  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;

  // Low address bits select the word
  assign wr_idx = wr_addr[IDX_W-1:0];
  assign rd_idx = rd_addr[IDX_W-1:0];

  // Write port, from the queue drain
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_idx] <= wr_data;
    end
  end

  // Registered read, old data on a same-edge collision
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_idx];
  end

endmodule

`default_nettype wire

/* source/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage import lsu_pkg::*; #(
  parameter int LSQ_SIZE = LSQ_SIZE_DEF
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       op_strobe,
  input  mem_op_t    op,
  input  lsq_entry_t entries [LSQ_SIZE],
  output addr_t      rd_addr,
  output lookup_t    lookup
);

  // Signed color distance, positive means a is younger
  function automatic logic is_younger(color_t a, color_t b);
    color_t diff;
    diff = a - b;
    return (diff != '0) && !diff[COLOR_W-1];
  endfunction

  mem_op_t op_q;
  logic    valid_q;
  logic    fwd_hit;
  word_t   fwd_value;
  color_t  fwd_color;

  // Input register, one op per cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= op_strobe;
    end
  end

  // Op payload, only loaded on a strobe
  always_ff @(posedge clk) begin
    if (op_strobe) begin
      op_q <= op;
    end
  end

  // Memory read issued in parallel with the queue search
  assign rd_addr = op_q.address;

  // Youngest valid store to the same address
  always_comb begin
    fwd_hit   = 1'b0;
    fwd_value = '0;
    fwd_color = '0;
    for (int i = 0; i < LSQ_SIZE; i++) begin
      if (entries[i].valid && (entries[i].address == op_q.address)) begin
        // First match, or one newer than the best so far
        if (!fwd_hit || is_younger(entries[i].color, fwd_color)) begin
          fwd_hit   = 1'b1;
          fwd_value = entries[i].value;
          fwd_color = entries[i].color;
        end
      end
    end
  end

  // Stage register toward writeback
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lookup <= '0;
    end else begin
      lookup.valid   <= valid_q;
      lookup.kind    <= op_q.kind;
      lookup.tag     <= op_q.tag;
      lookup.address <= op_q.address;
      if (op_q.kind == OP_STORE) begin
        // Store echoes its own data
        lookup.hit   <= 1'b1;
        lookup.value <= op_q.data;
      end else begin
        lookup.hit   <= fwd_hit;
        lookup.value <= fwd_value;
      end
    end
  end

endmodule

`default_nettype wire

/* source/lsq.sv */
`timescale 1ns/1ps
`default_nettype none

module lsq import lsu_pkg::*; #(
  parameter int LSQ_SIZE = LSQ_SIZE_DEF
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       store_strobe,
  input  mem_op_t    op,
  input  logic       drain_en,
  output lsq_entry_t entries [LSQ_SIZE],
  output logic       mem_wr_en,
  output addr_t      mem_wr_addr,
  output word_t      mem_wr_data,
  output logic       full,
  output logic       overflow
);

  localparam int PTR_W = $clog2(LSQ_SIZE);
  localparam int CNT_W = PTR_W + 1;

  // Larger queues would make color age ambiguous
  if (LSQ_SIZE > MAX_LSQ_SIZE) begin : g_size_check
    $error("lsq: LSQ_SIZE exceeds the color window");
  end

  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [CNT_W-1:0] count;
  color_t           color_next;
  logic             alloc;
  logic             drain;

  // Level full, all slots taken
  assign full = (count == CNT_W'(LSQ_SIZE));

  // Store dropped when no slot is free
  assign overflow = store_strobe && full;
  assign alloc    = store_strobe && !full;

  // Oldest store leaves when permitted
  assign drain = drain_en && (count != '0);

  // Memory write straight from the head slot
  assign mem_wr_en   = drain;
  assign mem_wr_addr = entries[head].address;
  assign mem_wr_data = entries[head].value;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      head       <= '0;
      tail       <= '0;
      count      <= '0;
      color_next <= '0;
      for (int i = 0; i < LSQ_SIZE; i++) begin
        entries[i] <= '0;
      end
    end else begin
      // Allocate at tail, stamped with the next color
      if (alloc) begin
        entries[tail].valid   <= 1'b1;
        entries[tail].tag     <= op.tag;
        entries[tail].address <= op.address;
        entries[tail].value   <= op.data;
        entries[tail].color   <= color_next;
        tail                  <= tail + 1'b1;
        color_next            <= color_next + 1'b1;
      end
      // Free head slot, never the same slot as alloc
      if (drain) begin
        entries[head].valid <= 1'b0;
        head                <= head + 1'b1;
      end
      // Occupancy
      case ({alloc, drain})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

  // Field widths
  localparam int ADDR_W  = 8;
  localparam int WORD_W  = 16;
  localparam int TAG_W   = 6;
  localparam int COLOR_W = 4;

  // Default sizing for the top level
  localparam int LSQ_SIZE_DEF  = 8;
  localparam int MEM_DEPTH_DEF = 256;

  // Colors must stay inside half the color space
  localparam int MAX_LSQ_SIZE = 2 ** (COLOR_W - 1);

  // Cycles from accepted op to result
  localparam int RESULT_LATENCY = 2;

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [WORD_W-1:0]  word_t;
  typedef logic [TAG_W-1:0]   tag_t;
  typedef logic [COLOR_W-1:0] color_t;

  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } op_kind_e;

  // Incoming memory operation
  typedef struct packed {
    op_kind_e kind;
    tag_t     tag;
    addr_t    address;
    word_t    data;
  } mem_op_t;

  // One store held in the queue
  typedef struct packed {
    logic   valid;
    tag_t   tag;
    addr_t  address;
    word_t  value;
    color_t color;
  } lsq_entry_t;

  // Stage register between lookup and writeback
  typedef struct packed {
    logic     valid;
    op_kind_e kind;
    tag_t     tag;
    addr_t    address;
    logic     hit;
    word_t    value;
  } lookup_t;

  // Final result seen by the core
  typedef struct packed {
    tag_t  tag;
    word_t value;
    logic  forwarded;
  } result_t;

endpackage

`default_nettype wire
